/* logic/draw_pkg.sv */
// ##################################################
// draw package: screen geometry, sprite ROM layout, shared types
// ##################################################

package draw_pkg;

	typedef logic [9:0]  coord_t;
	typedef logic [14:0] sprite_addr_t;
	typedef logic [15:0] sprite_data_t; // [3:0] r, [7:4] g, [11:8] b
	typedef logic [3:0]  color_t;
	typedef logic [15:0] bcd4_t; // msd in top nibble
	typedef logic [1:0]  lane_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_REQ,
		SEQ_RELEASE,
		SEQ_DONE
	} seq_state_t;

	localparam int NUM_LANES = 4;

	// lane rows and key indicator column
	localparam coord_t LANE_TOP        = 10'd200;
	localparam coord_t LANE_HEIGHT     = 10'd60;
	localparam coord_t INDICATOR_X     = 10'd420;
	localparam coord_t INDICATOR_WIDTH = 10'd60;

	// label and digit sprite sizes
	localparam coord_t SIGN_W  = 10'd24;
	localparam coord_t SIGN_H  = 10'd64;
	localparam coord_t DIGIT_W = 10'd24;
	localparam coord_t DIGIT_H = 10'd20;

	localparam sprite_addr_t DIGIT_SIZE = 15'd480; // glyph d at d*480
	localparam coord_t DIGIT_GAP = 10'd3;

	localparam coord_t X_PERFECT = 10'd396;
	localparam coord_t X_GREAT   = 10'd356;
	localparam coord_t X_GOOD    = 10'd316;
	localparam coord_t X_BAD     = 10'd276;
	localparam coord_t X_MISS    = 10'd236;

	localparam coord_t LABEL_Y = 10'd453;
	localparam coord_t DIGIT_Y = LABEL_Y + SIGN_H + 10'd10; // 527

	localparam coord_t COMBO_X = 10'd396;
	localparam coord_t COMBO_Y = 10'd98;

	// sprite ROM bases
	localparam sprite_addr_t BASE_PERFECT  = 15'd4800;
	localparam sprite_addr_t BASE_GREAT    = 15'd6336;
	localparam sprite_addr_t BASE_GOOD     = 15'd7872;
	localparam sprite_addr_t BASE_BAD      = 15'd9408;
	localparam sprite_addr_t BASE_MISS     = 15'd10944;
	localparam sprite_addr_t BASE_KEY_DOWN = 15'd19080;
	localparam sprite_addr_t BASE_KEY_UP   = 15'd22680;

	// request to colour, in cycles
	localparam int FETCH_LATENCY = 4;

endpackage

/* logic/frame_sequencer.sv */
// ##################################################
// frame sequencer: display enable, first-frame flag and
// lane-by-lane refresh over a four-phase req/ack
// ##################################################

`timescale 1ns/10ps

module frame_sequencer (
	input  logic            CLK,
	input  logic            RESET_L,
	input  logic            sig_on,
	input  logic            refresh_ack,
	output logic            refresh_req,
	output draw_pkg::lane_t refresh_lane,
	output logic            frame_done,
	output logic            vga_reset,
	output logic            is_first_frame
);
	import draw_pkg::*;

	seq_state_t state;
	seq_state_t next_state;
	lane_t      lane;
	logic       is_working;
	logic       last_lane;

	assign last_lane = lane == lane_t'(NUM_LANES - 1);

	// first start enables display, second one ends blanking
	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			is_working <= 1'b0;
			is_first_frame <= 1'b1;
		end else if (sig_on && state == SEQ_IDLE) begin
			if (!is_working)
				is_working <= 1'b1;
			else
				is_first_frame <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			state <= SEQ_IDLE;
			lane <= '0;
		end else begin
			state <= next_state;
			if (state == SEQ_IDLE)
				lane <= '0;
			else if (state == SEQ_RELEASE && !refresh_ack && !last_lane)
				lane <= lane + 1'b1; // next lane once ack drops
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			SEQ_IDLE: begin
				if (sig_on)
					next_state = SEQ_REQ;
			end
			SEQ_REQ: begin
				if (refresh_ack)
					next_state = SEQ_RELEASE;
			end
			SEQ_RELEASE: begin
				// wait for the refresher to drop ack
				if (!refresh_ack)
					next_state = last_lane ? SEQ_DONE : SEQ_REQ;
			end
			SEQ_DONE:
				next_state = SEQ_IDLE;
			default:
				next_state = SEQ_IDLE;
		endcase
	end

	assign refresh_req = state == SEQ_REQ;
	assign refresh_lane = lane;
	assign frame_done = state == SEQ_DONE;
	assign vga_reset = !is_working;

endmodule

/* logic/lane_indicator_addr.sv */
// ##################################################
// key indicator addressing: pressed or released art per lane
// ##################################################

`timescale 1ns/10ps

module lane_indicator_addr (
	input  draw_pkg::coord_t       vga_x,
	input  draw_pkg::coord_t       vga_y,
	input  logic [3:0]             is_key_down,
	output draw_pkg::sprite_addr_t lane_addr,
	output logic                   lane_hit
);
	import draw_pkg::*;

	logic         in_cols;
	logic         key_sel;
	coord_t       row_off;
	sprite_addr_t col_off;

	assign in_cols = vga_x >= INDICATOR_X && vga_x < INDICATOR_X + INDICATOR_WIDTH;

	// sprite stored column major, 60 words per column
	assign col_off = sprite_addr_t'(vga_x - INDICATOR_X) * sprite_addr_t'(INDICATOR_WIDTH);

	always_comb begin
		coord_t row_top;
		lane_hit = 1'b0;
		key_sel = 1'b0;
		row_off = '0;
		for (int i = 0; i < NUM_LANES; i++) begin
			row_top = LANE_TOP + coord_t'(i * LANE_HEIGHT);
			if (vga_y >= row_top && vga_y < row_top + LANE_HEIGHT) begin
				lane_hit = in_cols;
				key_sel = is_key_down[i];
				row_off = vga_y - row_top;
			end
		end
	end

	assign lane_addr = (key_sel ? BASE_KEY_DOWN : BASE_KEY_UP) + col_off
		+ sprite_addr_t'(row_off);

endmodule

/* logic/score_panel_addr.sv */
// ##################################################
// score panel addressing: judgement labels, their counts
// and the combo counter
// ##################################################

`timescale 1ns/10ps

module score_panel_addr (
	input  draw_pkg::coord_t       vga_x,
	input  draw_pkg::coord_t       vga_y,
	input  draw_pkg::bcd4_t        perfect,
	input  draw_pkg::bcd4_t        great,
	input  draw_pkg::bcd4_t        good,
	input  draw_pkg::bcd4_t        bad,
	input  draw_pkg::bcd4_t        miss,
	input  draw_pkg::bcd4_t        combo,
	output draw_pkg::sprite_addr_t panel_addr,
	output logic                   panel_hit
);
	import draw_pkg::*;

	// stacks 0..4 sit under the labels, 5 is combo
	coord_t       stack_x [6];
	coord_t       stack_y [6];
	bcd4_t        counts [6];
	sprite_addr_t label_base [5];

	assign stack_x[0] = X_PERFECT;
	assign stack_x[1] = X_GREAT;
	assign stack_x[2] = X_GOOD;
	assign stack_x[3] = X_BAD;
	assign stack_x[4] = X_MISS;
	assign stack_x[5] = COMBO_X;

	assign stack_y[0] = DIGIT_Y;
	assign stack_y[1] = DIGIT_Y;
	assign stack_y[2] = DIGIT_Y;
	assign stack_y[3] = DIGIT_Y;
	assign stack_y[4] = DIGIT_Y;
	assign stack_y[5] = COMBO_Y;

	assign counts[0] = perfect;
	assign counts[1] = great;
	assign counts[2] = good;
	assign counts[3] = bad;
	assign counts[4] = miss;
	assign counts[5] = combo;

	assign label_base[0] = BASE_PERFECT;
	assign label_base[1] = BASE_GREAT;
	assign label_base[2] = BASE_GOOD;
	assign label_base[3] = BASE_BAD;
	assign label_base[4] = BASE_MISS;

	always_comb begin
		coord_t       slot_top;
		logic [3:0]   glyph;
		panel_hit = 1'b0;
		panel_addr = '0;
		slot_top = '0;
		glyph = '0;

		// labels first, perfect wins
		for (int i = 0; i < 5; i++) begin
			if (!panel_hit && vga_x >= stack_x[i] && vga_x < stack_x[i] + SIGN_W
					&& vga_y >= LABEL_Y && vga_y < LABEL_Y + SIGN_H) begin
				panel_hit = 1'b1;
				panel_addr = label_base[i]
					+ sprite_addr_t'(vga_x - stack_x[i]) * sprite_addr_t'(SIGN_H)
					+ sprite_addr_t'(vga_y - LABEL_Y);
			end
		end

		// digit slots, slot 0 on top shows the msd
		for (int s = 0; s < 6; s++) begin
			for (int d = 0; d < 4; d++) begin
				slot_top = stack_y[s] + coord_t'(d * (DIGIT_H + DIGIT_GAP));
				if (!panel_hit && vga_x >= stack_x[s] && vga_x < stack_x[s] + DIGIT_W
						&& vga_y >= slot_top && vga_y < slot_top + DIGIT_H) begin
					panel_hit = 1'b1;
					glyph = counts[s][(3 - d) * 4 +: 4];
					panel_addr = sprite_addr_t'(glyph) * DIGIT_SIZE
						+ sprite_addr_t'(vga_x - stack_x[s]) * sprite_addr_t'(DIGIT_H)
						+ sprite_addr_t'(vga_y - slot_top);
				end
			end
		end
	end

endmodule

/* logic/pixel_fetch.sv */
// ##################################################
// pixel fetch: pipelined sprite ROM read into the VGA colour
// ##################################################

`timescale 1ns/10ps

module pixel_fetch (
	input  logic                   CLK,
	input  logic                   RESET_L,
	input  logic                   vga_request,
	input  logic                   is_first_frame,
	input  draw_pkg::sprite_addr_t lane_addr,
	input  logic                   lane_hit,
	input  draw_pkg::sprite_addr_t panel_addr,
	input  logic                   panel_hit,
	input  draw_pkg::sprite_data_t sprite_data,
	output logic                   sprite_en,
	output draw_pkg::sprite_addr_t sprite_addr,
	output draw_pkg::color_t       vga_r,
	output draw_pkg::color_t       vga_g,
	output draw_pkg::color_t       vga_b
);
	import draw_pkg::*;

	sprite_addr_t             pick_addr;
	logic [FETCH_LATENCY-2:0] valid_pipe; // [0] is the ROM enable
	logic [FETCH_LATENCY-2:0] blank_pipe;

	// lanes over panel, background reads word 0
	always_comb begin
		if (lane_hit)
			pick_addr = lane_addr;
		else if (panel_hit)
			pick_addr = panel_addr;
		else
			pick_addr = '0;
	end

	always_ff @(posedge CLK) begin
		if (!RESET_L)
			valid_pipe <= '0;
		else
			valid_pipe <= {valid_pipe[FETCH_LATENCY-3:0], vga_request};
	end

	always_ff @(posedge CLK) begin
		if (vga_request)
			sprite_addr <= pick_addr;
		blank_pipe <= {blank_pipe[FETCH_LATENCY-3:0], is_first_frame};
	end

	assign sprite_en = valid_pipe[0];

	// ROM word is valid alongside the last stage
	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else if (valid_pipe[FETCH_LATENCY-2]) begin
			if (blank_pipe[FETCH_LATENCY-2]) begin
				vga_r <= '0;
				vga_g <= '0;
				vga_b <= '0;
			end else begin
				vga_r <= sprite_data[3:0];
				vga_g <= sprite_data[7:4];
				vga_b <= sprite_data[11:8];
			end
		end
	end

endmodule

/* logic/draw_controller.sv */
// ##################################################
// draw controller: frame sequencing and sprite drawing top
// ##################################################

`timescale 1ns/10ps

module draw_controller (
	input  logic                   CLK,
	input  logic                   RESET_L,
	input  logic                   sig_on,
	output logic                   frame_done,
	output logic                   refresh_req,
	output draw_pkg::lane_t        refresh_lane,
	input  logic                   refresh_ack,
	output logic                   sprite_en,
	output draw_pkg::sprite_addr_t sprite_addr,
	input  draw_pkg::sprite_data_t sprite_data,
	input  logic [3:0]             is_key_down,
	input  draw_pkg::bcd4_t        perfect,
	input  draw_pkg::bcd4_t        great,
	input  draw_pkg::bcd4_t        good,
	input  draw_pkg::bcd4_t        bad,
	input  draw_pkg::bcd4_t        miss,
	input  draw_pkg::bcd4_t        combo,
	input  draw_pkg::coord_t       vga_x,
	input  draw_pkg::coord_t       vga_y,
	input  logic                   vga_request,
	output draw_pkg::color_t       vga_r,
	output draw_pkg::color_t       vga_g,
	output draw_pkg::color_t       vga_b,
	output logic                   vga_reset
);
	import draw_pkg::*;

	logic         is_first_frame;
	sprite_addr_t lane_addr;
	logic         lane_hit;
	sprite_addr_t panel_addr;
	logic         panel_hit;

	frame_sequencer frame_sequencer_i (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.sig_on(sig_on),
		.refresh_ack(refresh_ack),
		.refresh_req(refresh_req),
		.refresh_lane(refresh_lane),
		.frame_done(frame_done),
		.vga_reset(vga_reset),
		.is_first_frame(is_first_frame)
	);

	lane_indicator_addr lane_indicator_addr_i (
		.vga_x(vga_x),
		.vga_y(vga_y),
		.is_key_down(is_key_down),
		.lane_addr(lane_addr),
		.lane_hit(lane_hit)
	);

	score_panel_addr score_panel_addr_i (
		.vga_x(vga_x),
		.vga_y(vga_y),
		.perfect(perfect),
		.great(great),
		.good(good),
		.bad(bad),
		.miss(miss),
		.combo(combo),
		.panel_addr(panel_addr),
		.panel_hit(panel_hit)
	);

	pixel_fetch pixel_fetch_i (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.vga_request(vga_request),
		.is_first_frame(is_first_frame),
		.lane_addr(lane_addr),
		.lane_hit(lane_hit),
		.panel_addr(panel_addr),
		.panel_hit(panel_hit),
		.sprite_data(sprite_data),
		.sprite_en(sprite_en),
		.sprite_addr(sprite_addr),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

endmodule

/* sim/draw_controller_chk.sv */
// ##################################################
// draw controller assertions: refresh handshake,
// fetch enable and reset state
// ##################################################

`timescale 1ns/10ps

module draw_controller_chk (
	input logic            CLK,
	input logic            RESET_L,
	input logic            refresh_req,
	input logic            refresh_ack,
	input draw_pkg::lane_t refresh_lane,
	input logic            frame_done,
	input logic            vga_request,
	input logic            sprite_en
);

	// req and lane hold until the refresher acks
	assert property (@(posedge CLK) disable iff (!RESET_L)
		refresh_req && !refresh_ack |=> refresh_req && $stable(refresh_lane))
		else $error("refresh_req or refresh_lane changed before refresh_ack");

	assert property (@(posedge CLK) disable iff (!RESET_L)
		sprite_en == $past(vga_request))
		else $error("sprite_en does not follow vga_request by one cycle");

	assert property (@(posedge CLK) disable iff (!RESET_L) frame_done |=> !frame_done)
		else $error("frame_done longer than one cycle");

	assert property (@(posedge CLK) !RESET_L |=> !refresh_req && !frame_done && !sprite_en)
		else $error("outputs active after reset");

endmodule

bind draw_controller draw_controller_chk draw_controller_chk_i (.*);

/* sim/draw_controller_tb.sv */
// ##################################################
// draw controller testbench: frame sequencing, blanking,
// key and score sprites and the fetch pipeline
// ##################################################

`timescale 1ns/10ps

module draw_controller_tb;
	import draw_pkg::*;

	localparam int NUM_TESTS = 6;
	localparam coord_t STACK_X [6] = '{X_PERFECT, X_GREAT, X_GOOD, X_BAD, X_MISS, COMBO_X};
	localparam coord_t STACK_Y [6] = '{DIGIT_Y, DIGIT_Y, DIGIT_Y, DIGIT_Y, DIGIT_Y, COMBO_Y};
	localparam sprite_addr_t LABEL_BASE [5] =
		'{BASE_PERFECT, BASE_GREAT, BASE_GOOD, BASE_BAD, BASE_MISS};

	logic         CLK = 1'b0;
	logic         RESET_L = 1'b0;
	logic         sig_on = 1'b0;
	logic         refresh_ack = 1'b0;
	logic         vga_request = 1'b0;
	logic [3:0]   is_key_down = '0;
	coord_t       vga_x = '0;
	coord_t       vga_y = '0;
	sprite_data_t sprite_data = '0;
	bcd4_t        perfect = '0;
	bcd4_t        great = '0;
	bcd4_t        good = '0;
	bcd4_t        bad = '0;
	bcd4_t        miss = '0;
	bcd4_t        combo = '0;
	logic         frame_done;
	logic         refresh_req;
	lane_t        refresh_lane;
	logic         sprite_en;
	sprite_addr_t sprite_addr;
	color_t       vga_r;
	color_t       vga_g;
	color_t       vga_b;
	logic         vga_reset;

	logic [31:0]  lfsr = 32'he2a189a8;
	sprite_addr_t rom_addr_q;
	logic         rom_en_q = 1'b0;
	int           done_count = 0;
	int           errors = 0;
	int           tests_failed = 0;
	coord_t       px_x [$];
	coord_t       px_y [$];

	draw_controller draw_controller_i (.*);

	always #4 CLK = ~CLK;

	// two-cycle sprite ROM
	always @(posedge CLK) begin
		rom_en_q <= sprite_en;
		rom_addr_q <= sprite_addr;
		if (rom_en_q)
			sprite_data <= sprite_data_t'((int'(rom_addr_q) * 5 + 3) % 4096);
	end

	always @(negedge CLK)
		if (frame_done)
			done_count <= done_count + 1;

	initial begin
		repeat (NUM_TESTS * 2000) @(posedge CLK);
		$display("watchdog expired after %0d cycles, run is stuck", NUM_TESTS * 2000);
		$display("TEST FAIL");
		$finish;
	end

	function automatic int rand_bits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			r = (r << 1) | int'(lfsr[0]);
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1; // galois step
		end
		return r;
	endfunction

	function automatic bcd4_t rand_bcd();
		bcd4_t v;
		for (int d = 0; d < 4; d++)
			v[d * 4 +: 4] = 4'(rand_bits(4) % 10);
		return v;
	endfunction

	// priority is lanes then labels then digit slots and word 0 elsewhere
	function automatic sprite_addr_t expected_addr(input coord_t x, input coord_t y);
		bcd4_t counts [6];
		int dx;
		int dy;
		int slot;
		counts = '{perfect, great, good, bad, miss, combo};
		dx = int'(x) - int'(INDICATOR_X);
		dy = int'(y) - int'(LANE_TOP);
		if (dx >= 0 && dx < int'(INDICATOR_WIDTH) && dy >= 0
				&& dy < NUM_LANES * int'(LANE_HEIGHT)) begin
			slot = dy / int'(LANE_HEIGHT);
			return sprite_addr_t'((is_key_down[slot] ? int'(BASE_KEY_DOWN) : int'(BASE_KEY_UP))
				+ dx * int'(LANE_HEIGHT) + dy % int'(LANE_HEIGHT));
		end
		for (int i = 0; i < 5; i++) begin
			dx = int'(x) - int'(STACK_X[i]);
			dy = int'(y) - int'(LABEL_Y);
			if (dx >= 0 && dx < int'(SIGN_W) && dy >= 0 && dy < int'(SIGN_H))
				return sprite_addr_t'(int'(LABEL_BASE[i]) + dx * int'(SIGN_H) + dy);
		end
		for (int s = 0; s < 6; s++) begin
			dx = int'(x) - int'(STACK_X[s]);
			dy = int'(y) - int'(STACK_Y[s]);
			slot = dy / int'(DIGIT_H + DIGIT_GAP);
			if (dx >= 0 && dx < int'(DIGIT_W) && dy >= 0 && slot < 4
					&& dy % int'(DIGIT_H + DIGIT_GAP) < int'(DIGIT_H))
				return sprite_addr_t'(int'(counts[s][(3 - slot) * 4 +: 4]) * int'(DIGIT_SIZE)
					+ dx * int'(DIGIT_H) + dy % int'(DIGIT_H + DIGIT_GAP));
		end
		return '0;
	endfunction

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			errors++;
			$display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input sprite_addr_t got, input sprite_addr_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_lane(input lane_t got, input lane_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_color(input color_t got, input color_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// red in the low nibble of the ROM word and blue at the top
	task automatic check_rgb(input sprite_addr_t addr, input logic blank);
		int word;
		word = blank ? 0 : (int'(addr) * 5 + 3) % 4096;
		check_color(vga_r, color_t'(word % 16), "vga_r");
		check_color(vga_g, color_t'(word / 16 % 16), "vga_g");
		check_color(vga_b, color_t'(word / 256), "vga_b");
	endtask

	task automatic report_test(input string name, input int mark);
		if (errors == mark)
			$display("%s: ok", name);
		else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - mark);
		end
	endtask

	task automatic pulse_sig_on();
		@(posedge CLK);
		sig_on <= 1'b1;
		@(posedge CLK);
		sig_on <= 1'b0;
	endtask

	// refresher side of one four-phase exchange
	task automatic serve_lane(input int lane);
		@(negedge CLK);
		while (!refresh_req) @(negedge CLK);
		check_lane(refresh_lane, lane_t'(lane), "refresh_lane");
		repeat (1 + rand_bits(3)) @(posedge CLK);
		refresh_ack <= 1'b1;
		@(negedge CLK);
		while (refresh_req) @(negedge CLK);
		repeat (rand_bits(3)) begin
			@(negedge CLK);
			check_flag(refresh_req, 1'b0, "refresh_req while ack is high");
		end
		@(posedge CLK);
		refresh_ack <= 1'b0;
	endtask

	task automatic run_frame(input logic mid_start);
		int done_before;
		done_before = done_count;
		pulse_sig_on();
		for (int lane = 0; lane < NUM_LANES; lane++) begin
			serve_lane(lane);
			if (mid_start && lane == 1)
				pulse_sig_on(); // ignored while the frame is busy
		end
		check_count(done_count - done_before, 0, "frame_done before last release");
		while (done_count == done_before) @(negedge CLK);
		repeat (12) begin
			@(negedge CLK);
			check_flag(refresh_req, 1'b0, "refresh_req after frame");
		end
		check_count(done_count - done_before, 1, "frame_done pulses");
	endtask

	task automatic add_pixel(input int x, input int y);
		px_x.push_back(coord_t'(x));
		px_y.push_back(coord_t'(y));
	endtask

	// one request per cycle with the address one cycle and the colour four cycles later
	task automatic run_pixels(input logic blank);
		int n;
		sprite_addr_t ea [$];
		n = px_x.size();
		for (int j = 0; j < n + 4; j++) begin
			@(posedge CLK);
			vga_request <= j < n;
			if (j < n) begin
				vga_x <= px_x[j];
				vga_y <= px_y[j];
			end
			@(negedge CLK);
			if (j < n)
				ea.push_back(expected_addr(px_x[j], px_y[j]));
			if (j >= 1 && j <= n) begin
				check_flag(sprite_en, 1'b1, "sprite_en");
				check_addr(sprite_addr, ea[j - 1], "sprite_addr");
			end
			if (j >= 4)
				check_rgb(ea[j - 4], blank);
		end
		px_x.delete();
		px_y.delete();
	endtask

	task automatic test_reset();
		@(negedge CLK);
		check_flag(vga_reset, 1'b1, "vga_reset");
		check_flag(refresh_req, 1'b0, "refresh_req");
		check_flag(frame_done, 1'b0, "frame_done");
		check_flag(sprite_en, 1'b0, "sprite_en");
		check_rgb('0, 1'b1);
	endtask

	task automatic test_frame();
		run_frame(1'b1);
		check_flag(vga_reset, 1'b0, "vga_reset after start");
	endtask

	task automatic test_blanking();
		add_pixel(430, 210);
		add_pixel(400, 460);
		add_pixel(10, 10);
		add_pixel(445, 430);
		add_pixel(396, 527);
		run_pixels(1'b1);
	endtask

	task automatic test_key_indicators();
		run_frame(1'b0); // second start ends blanking
		@(posedge CLK);
		is_key_down <= 4'(rand_bits(4));
		for (int lane = 0; lane < NUM_LANES; lane++)
			for (int k = 0; k < 3; k++)
				add_pixel(int'(INDICATOR_X) + rand_bits(6) % 60,
					int'(LANE_TOP) + lane * int'(LANE_HEIGHT) + rand_bits(6) % 60);
		add_pixel(420, 200);
		add_pixel(479, 439);
		add_pixel(480, 250); // just right of the keys
		add_pixel(419, 210);
		run_pixels(1'b0);
	endtask

	task automatic test_score_panel();
		@(posedge CLK);
		perfect <= rand_bcd();
		great <= rand_bcd();
		good <= rand_bcd();
		bad <= rand_bcd();
		miss <= rand_bcd();
		combo <= rand_bcd();
		for (int i = 0; i < 5; i++)
			add_pixel(int'(STACK_X[i]) + rand_bits(4), int'(LABEL_Y) + rand_bits(6));
		for (int s = 0; s < 6; s++) begin
			for (int d = 0; d < 4; d++)
				add_pixel(int'(STACK_X[s]) + rand_bits(4),
					int'(STACK_Y[s]) + d * 23 + rand_bits(4));
			add_pixel(int'(STACK_X[s]) + 23, int'(STACK_Y[s]) + 21); // gap row
		end
		add_pixel(10, 10);
		add_pixel(600, 300);
		run_pixels(1'b0);
	endtask

	task automatic test_pipeline();
		for (int i = 0; i < 12; i++) begin
			add_pixel(int'(INDICATOR_X) + rand_bits(6) % 60, int'(LANE_TOP) + rand_bits(8) % 240);
			add_pixel(230 + rand_bits(8), 90 + rand_bits(9));
		end
		run_pixels(1'b0);
	endtask

	initial begin
		int mark;
		repeat (2) @(posedge CLK);
		RESET_L <= 1'b1;
		mark = errors;
		test_reset();
		report_test("reset state", mark);
		mark = errors;
		test_frame();
		report_test("frame sequencing", mark);
		mark = errors;
		test_blanking();
		report_test("first-frame blanking", mark);
		mark = errors;
		test_key_indicators();
		report_test("key indicators", mark);
		mark = errors;
		test_score_panel();
		report_test("score panel", mark);
		mark = errors;
		test_pipeline();
		report_test("pipelined fetch", mark);
		$display("%0d tests, %0d failed, %0d errors", NUM_TESTS, tests_failed, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* list.f */
logic/draw_pkg.sv
logic/frame_sequencer.sv
logic/lane_indicator_addr.sv
logic/score_panel_addr.sv
logic/pixel_fetch.sv
logic/draw_controller.sv
sim/draw_controller_chk.sv
sim/draw_controller_tb.sv

/* run.sh */
#!/bin/sh
# build the draw controller testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module draw_controller_tb -Mdir obj_dir &&
./obj_dir/Vdraw_controller_tb | tee /dev/stderr | grep "TEST PASS" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
